//--- Bender.yml
package:
  name: pkt_comm

sources:
  - src/pkt_comm_pkg.sv
  - src/pkt_header.sv
  - src/word_buffer.sv
  - src/word_emitter.sv
  - src/apb_regs.sv
  - src/pkt_comm_top.sv
  - target: test
    files:
      - bench/tb_clk_gen.sv
      - bench/pkt_comm_checker.sv
      - bench/pkt_comm_tb.sv

//--- bench/pkt_comm_checker.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_comm_checker import pkt_comm_pkg::*; (
	input wire logic CLK,
	input wire logic arst_n,
	input wire logic in_ready,
	input wire logic err_pending,
	input wire out_beat_t out_beat,
	input wire logic out_valid,
	input wire logic out_ready,
	input wire apb_req_t apb_req,
	input wire apb_rsp_t apb_rsp
);

	// assertion failures so far
	int fail_count = 0;

	logic access;
	logic bad_addr;
	logic ro_write;

	// access phase and the two reasons for a slave error
	assign access = apb_req.psel && apb_req.penable;
	assign bad_addr = !(apb_req.paddr inside
		{REG_CTRL, REG_STATUS, REG_CMP_CFG, REG_WORD_COUNT});
	assign ro_write = apb_req.pwrite
		&& (apb_req.paddr inside {REG_CMP_CFG, REG_WORD_COUNT});

	// ************************************************************
	// output stream, parser halt, APB response
	// ************************************************************
	// a stalled beat stays put until it is taken
	beat_held: assert property (@(posedge CLK) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_beat))
		else begin
			fail_count++;
			$error("out_beat or out_valid changed while out_ready was low");
		end

	// no byte is taken while a sticky error waits to be cleared
	halt_blocks_input: assert property (@(posedge CLK) disable iff (!arst_n)
		err_pending |-> !in_ready)
		else begin
			fail_count++;
			$error("in_ready high while a status flag is still set");
		end

	// slave error exactly on a bad access phase
	slverr_rule: assert property (@(posedge CLK) disable iff (!arst_n)
		apb_rsp.pslverr == (access && (bad_addr || ro_write)))
		else begin
			fail_count++;
			$error("pslverr does not match the address and direction of the access");
		end

endmodule

// the parser stays halted while any status flag is set
bind pkt_comm_top pkt_comm_checker u_checker (
	.CLK(CLK),
	.arst_n(arst_n),
	.in_ready(in_ready),
	.err_pending(u_regs.status != '0),
	.out_beat(out_beat),
	.out_valid(out_valid),
	.out_ready(out_ready),
	.apb_req(apb_req),
	.apb_rsp(apb_rsp)
);

`default_nettype wire

//--- bench/pkt_comm_tb.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_comm_tb import pkt_comm_pkg::*; ();

	localparam int PKT_MAX_LEN = 64;
	localparam int WORD_MAX_LEN = 8;
	localparam int BUF_DEPTH = 16;
	localparam int N_ROWS = 10;
	// one extra slot for the APB error test at the end
	localparam int TIMEOUT_CYCLES = 200 * (N_ROWS + 1);

	typedef enum {C_NONE, C_VERSION, C_TYPE, C_LEN, C_CSUM} corrupt_t;

	// '/' in words stands for the zero byte that closes a word
	typedef struct {
		logic [15:0] id;
		logic [7:0] ptype;
		string words;
		logic [31:0] cfg;
		corrupt_t corrupt;
		logic [4:0] exp_status;
		int exp_count;
	} test_row_t;

	logic CLK;
	logic arst_n;
	logic [7:0] in_data;
	logic in_valid;
	logic in_ready;
	out_beat_t out_beat;
	logic out_valid;
	logic out_ready;
	apb_req_t apb_req;
	apb_rsp_t apb_rsp;

	test_row_t rows [N_ROWS];
	logic [7:0] stream [$];
	logic [7:0] cur_word [$];
	out_beat_t exp_beats [$];
	out_beat_t got_beats [$];
	logic [31:0] exp_cfg;
	logic hold_out;
	bit saw_full;
	int errors;
	int failed;

	tb_clk_gen #(.PERIOD_NS(100), .RST_CYCLES(2)) u_clk (.CLK(CLK), .arst_n(arst_n));

	pkt_comm_top #(
		.PKT_MAX_LEN(PKT_MAX_LEN),
		.WORD_MAX_LEN(WORD_MAX_LEN),
		.BUF_DEPTH(BUF_DEPTH)
	) dut (
		.CLK(CLK), .arst_n(arst_n),
		.in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
		.out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
		.apb_req(apb_req), .apb_rsp(apb_rsp)
	);

	// ************************************************************
	// output side beat capture
	// ************************************************************
	always @(posedge CLK)
		if (arst_n && out_valid && out_ready)
			got_beats.push_back(out_beat);

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			errors++;
			$display("ERR %0t %s: got %h, expected %h", $time, name, got, exp);
		end
	endtask

	// setup phase, then access phase sampled mid cycle
	task automatic apb_xfer(input logic write, input logic [3:0] addr,
			input logic [31:0] wdata, output logic [31:0] rdata, output logic slverr);
		apb_req.psel <= 1'b1;
		apb_req.penable <= 1'b0;
		apb_req.pwrite <= write;
		apb_req.paddr <= addr;
		apb_req.pwdata <= wdata;
		@(posedge CLK);
		apb_req.penable <= 1'b1;
		@(negedge CLK);
		rdata = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(posedge CLK);
		apb_req <= '0;
	endtask

	// a full buffer stops the input, then the output is let go
	task automatic send_stream();
		foreach (stream[k]) begin
			in_data <= stream[k];
			in_valid <= 1'b1;
			@(posedge CLK);
			while (!in_ready) begin
				saw_full = 1'b1;
				hold_out <= 1'b0;
				@(posedge CLK);
			end
		end
		in_valid <= 1'b0;
	endtask

	// ************************************************************
	// reference model
	// ************************************************************
	// id beat, index beat, then character pairs with the first char low
	task automatic add_word(input logic [15:0] id, input int idx);
		out_beat_t beat;
		int n;
		n = cur_word.size();
		beat.data = id;
		beat.last = 1'b0;
		exp_beats.push_back(beat);
		beat.data = 16'(idx);
		beat.last = (n == 0);
		exp_beats.push_back(beat);
		for (int k = 0; k < n; k += 2) begin
			beat.data[7:0] = cur_word[k];
			beat.data[15:8] = (k + 1 < n) ? cur_word[k + 1] : 8'h00;
			beat.last = (k + 2 >= n);
			exp_beats.push_back(beat);
		end
		cur_word.delete();
	endtask

	// bytes that the parser will accept, and the beats they should give
	task automatic build_packet(input test_row_t row);
		logic [7:0] payload [$];
		logic [7:0] csum;
		logic [15:0] len;
		logic [7:0] b;
		int widx;
		bit bad_word;
		stream.delete();
		exp_beats.delete();
		cur_word.delete();
		csum = '0;
		widx = 0;
		bad_word = 1'b0;
		if (row.ptype == PKT_TYPE_CMP_CONFIG) begin
			for (int k = 0; k < CMP_CFG_LEN; k++)
				payload.push_back(row.cfg[8*k +: 8]);
		end else begin
			for (int k = 0; k < row.words.len(); k++)
				payload.push_back((row.words[k] == "/") ? 8'h00 : row.words[k]);
		end
		len = (row.corrupt == C_LEN) ? 16'(PKT_MAX_LEN + 1) : 16'(payload.size());
		stream.push_back((row.corrupt == C_VERSION) ? PKT_VERSION + 8'd1 : PKT_VERSION);
		stream.push_back((row.corrupt == C_TYPE) ? 8'h02 : row.ptype);
		stream.push_back(row.id[7:0]);
		stream.push_back(row.id[15:8]);
		stream.push_back(len[7:0]);
		stream.push_back(len[15:8]);
		// a bad header halts the parser after its last byte
		if (row.corrupt inside {C_VERSION, C_TYPE, C_LEN})
			return;
		foreach (payload[k]) begin
			b = payload[k];
			stream.push_back(b);
			csum = csum + b;
			if (row.ptype == PKT_TYPE_WORD_LIST) begin
				if (b != 8'h00 && (cur_word.size() == WORD_MAX_LEN || k == payload.size() - 1)) begin
					// offending byte closes the word and halts the parser
					add_word(row.id, widx);
					bad_word = 1'b1;
					break;
				end else if (b != 8'h00) begin
					cur_word.push_back(b);
				end else begin
					add_word(row.id, widx);
					widx++;
				end
			end
		end
		if (!bad_word)
			stream.push_back((row.corrupt == C_CSUM) ? csum + 8'd1 : csum);
	endtask

	// ************************************************************
	// test table
	// ************************************************************
	// expected word count is the running total
	task automatic fill_table();
		rows[0] = '{16'h0101, PKT_TYPE_WORD_LIST, "/ABC/ABCDEFGH/", 32'h0, C_NONE, 5'h00, 3};
		rows[1] = '{16'h0202, PKT_TYPE_CMP_CONFIG, "", 32'hA5C3_1E07, C_NONE, 5'h00, 3};
		rows[2] = '{16'h0303, PKT_TYPE_CMP_CONFIG, "", 32'h1234_5678, C_CSUM, 5'h02, 3};
		rows[3] = '{16'h0404, PKT_TYPE_WORD_LIST, "HELLO/", 32'h0, C_VERSION, 5'h10, 3};
		rows[4] = '{16'h0505, PKT_TYPE_WORD_LIST, "XY/", 32'h0, C_NONE, 5'h00, 4};
		rows[5] = '{16'h0606, PKT_TYPE_WORD_LIST, "AB/", 32'h0, C_TYPE, 5'h08, 4};
		rows[6] = '{16'h0707, PKT_TYPE_WORD_LIST, "AB/", 32'h0, C_LEN, 5'h04, 4};
		// nine characters, the first eight still come out as a word
		rows[7] = '{16'h0808, PKT_TYPE_WORD_LIST, "OK/ABCDEFGHI/", 32'h0, C_NONE, 5'h01, 6};
		rows[8] = '{16'h0909, PKT_TYPE_WORD_LIST, "/Z/QRSTUVW/", 32'h0, C_NONE, 5'h00, 9};
		// longer than the buffer, a held output fills it
		rows[9] = '{16'h0A0A, PKT_TYPE_WORD_LIST, "ABCDEFGH/12345678/abcdefgh/", 32'h0,
			C_NONE, 5'h00, 12};
	endtask

	task automatic run_row(input int r);
		int err_before;
		logic [31:0] rdata;
		logic slverr;
		bit fills_buf;
		err_before = errors;
		fills_buf = (rows[r].words.len() > BUF_DEPTH);
		build_packet(rows[r]);
		got_beats.delete();
		saw_full = 1'b0;
		hold_out <= fills_buf;
		send_stream();
		if (fills_buf)
			check("in_ready back-pressure", saw_full, 1'b1);
		while (got_beats.size() < exp_beats.size())
			@(posedge CLK);
		// status, config and count settle one cycle after their event
		repeat (3) @(posedge CLK);
		check("beat count", got_beats.size(), exp_beats.size());
		for (int k = 0; k < exp_beats.size() && k < got_beats.size(); k++)
			check($sformatf("out_beat[%0d]", k), got_beats[k], exp_beats[k]);
		if (rows[r].ptype == PKT_TYPE_CMP_CONFIG && rows[r].corrupt == C_NONE)
			exp_cfg = rows[r].cfg;
		apb_xfer(1'b0, REG_STATUS, '0, rdata, slverr);
		check("STATUS", rdata, rows[r].exp_status);
		apb_xfer(1'b0, REG_WORD_COUNT, '0, rdata, slverr);
		check("WORD_COUNT", rdata, rows[r].exp_count);
		apb_xfer(1'b0, REG_CMP_CFG, '0, rdata, slverr);
		check("CMP_CFG", rdata, exp_cfg);
		if (rows[r].exp_status != '0) begin
			apb_xfer(1'b1, REG_STATUS, 32'h1F, rdata, slverr);
			apb_xfer(1'b0, REG_STATUS, '0, rdata, slverr);
			check("STATUS after clear", rdata, 32'h0);
		end
		if (errors != err_before)
			failed++;
		$display("row %0d id %h: %s", r, rows[r].id, (errors == err_before) ? "ok" : "mismatch");
	endtask

	// unmapped addresses and writes to read-only registers
	task automatic apb_error_test();
		int err_before;
		logic [31:0] rdata;
		logic slverr;
		err_before = errors;
		apb_xfer(1'b0, 4'h1, '0, rdata, slverr);
		check("pslverr unmapped read", slverr, 1'b1);
		apb_xfer(1'b1, 4'h6, 32'h0, rdata, slverr);
		check("pslverr unmapped write", slverr, 1'b1);
		apb_xfer(1'b1, REG_WORD_COUNT, 32'h0, rdata, slverr);
		check("pslverr WORD_COUNT write", slverr, 1'b1);
		apb_xfer(1'b1, REG_CMP_CFG, 32'hFFFF_FFFF, rdata, slverr);
		check("pslverr CMP_CFG write", slverr, 1'b1);
		apb_xfer(1'b0, REG_WORD_COUNT, '0, rdata, slverr);
		check("WORD_COUNT", rdata, rows[N_ROWS-1].exp_count);
		check("pslverr WORD_COUNT read", slverr, 1'b0);
		apb_xfer(1'b0, REG_CMP_CFG, '0, rdata, slverr);
		check("CMP_CFG", rdata, exp_cfg);
		apb_xfer(1'b0, REG_CTRL, '0, rdata, slverr);
		check("CTRL", rdata, 32'h1);
		apb_xfer(1'b0, REG_STATUS, '0, rdata, slverr);
		check("STATUS", rdata, 32'h0);
		if (errors != err_before)
			failed++;
		$display("apb errors: %s", (errors == err_before) ? "ok" : "mismatch");
	endtask

	// ************************************************************
	// main sequence and watchdog
	// ************************************************************
	initial begin
		logic [31:0] rdata;
		logic slverr;
		in_data = '0;
		in_valid = 1'b0;
		out_ready = 1'b0;
		apb_req = '0;
		hold_out = 1'b0;
		saw_full = 1'b0;
		errors = 0;
		failed = 0;
		exp_cfg = '0;
		void'($urandom(32'h1772));
		// random stalls on the output side, one draw per clock
		fork
			forever begin
				@(posedge CLK);
				out_ready <= !hold_out && ($urandom % 4 != 0);
			end
		join_none
		fill_table();
		wait (arst_n === 1'b1);
		@(posedge CLK);
		apb_xfer(1'b1, REG_CTRL, 32'h1, rdata, slverr);
		for (int r = 0; r < N_ROWS; r++)
			run_row(r);
		apb_error_test();
		if (dut.u_checker.fail_count != 0) begin
			errors += dut.u_checker.fail_count;
			$display("assertion failures in the checker: %0d", dut.u_checker.fail_count);
		end
		$display("tests %0d, failed %0d, errors %0d", N_ROWS + 1, failed, errors);
		if (errors == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

	initial begin
		repeat (TIMEOUT_CYCLES) @(posedge CLK);
		$display("timeout: the tests did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/tb_clk_gen.sv
`timescale 1ns/10ps
`default_nettype none

module tb_clk_gen #(
	parameter int PERIOD_NS = 100,
	parameter int RST_CYCLES = 2
) (
	output logic CLK,
	output logic arst_n
);

	// free running clock, low for the first half period
	initial begin
		CLK = 1'b0;
		forever #(PERIOD_NS / 2) CLK = ~CLK;
	end

	// reset held over the first rising edges, released on an edge
	initial begin
		arst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge CLK);
		arst_n <= 1'b1;
	end

endmodule

`default_nettype wire

//--- list.f
src/pkt_comm_pkg.sv
src/pkt_header.sv
src/word_buffer.sv
src/word_emitter.sv
src/apb_regs.sv
src/pkt_comm_top.sv
bench/tb_clk_gen.sv
bench/pkt_comm_checker.sv
bench/pkt_comm_tb.sv

//--- src/apb_regs.sv
`timescale 1ns/10ps
`default_nettype none

module apb_regs import pkt_comm_pkg::*; (
	input wire logic CLK,
	input wire logic arst_n,
	input wire apb_req_t apb_req,
	output apb_rsp_t apb_rsp,
	output logic enable,
	input wire err_bits_t err_set,
	output logic err_clear,
	input wire logic cfg_valid,
	input wire logic [CFG_W-1:0] cfg_data,
	input wire logic word_done
);

	localparam int ERR_W = $bits(err_bits_t);

	err_bits_t status;
	err_bits_t status_nxt;
	logic [CFG_W-1:0] cmp_cfg;
	logic [APB_DW-1:0] word_count;

	logic access;
	logic addr_ok;
	logic read_only;
	logic slverr;
	logic wr_ok;
	logic [ERR_W-1:0] clr_mask;
	logic [APB_DW-1:0] rdata;

	// ************************************************************
	// address decode and read mux
	// ************************************************************
	assign access = apb_req.psel && apb_req.penable;

	always_comb begin
		addr_ok = 1'b1;
		read_only = 1'b0;
		rdata = '0;
		case (apb_req.paddr)
			REG_CTRL: rdata = {{(APB_DW - 1){1'b0}}, enable};
			REG_STATUS: rdata = {{(APB_DW - ERR_W){1'b0}}, status};
			REG_CMP_CFG: begin
				read_only = 1'b1;
				rdata = cmp_cfg;
			end
			REG_WORD_COUNT: begin
				read_only = 1'b1;
				rdata = word_count;
			end
			default: addr_ok = 1'b0;
		endcase
	end

	// unmapped address or write to a read-only register
	assign slverr = access && (!addr_ok || (apb_req.pwrite && read_only));
	assign wr_ok = access && apb_req.pwrite && !slverr;

	assign apb_rsp.pslverr = slverr;
	assign apb_rsp.prdata = (access && !apb_req.pwrite && addr_ok) ? rdata : '0;

	// write one to clear, a new error in the same cycle wins
	assign clr_mask = (wr_ok && apb_req.paddr == REG_STATUS) ? apb_req.pwdata[ERR_W-1:0] : '0;
	assign status_nxt = err_bits_t'((status & ~clr_mask) | err_set);

	// ************************************************************
	// registers
	// ************************************************************
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			enable <= 1'b0;
			status <= '0;
			err_clear <= 1'b0;
			cmp_cfg <= '0;
			word_count <= '0;
		end else begin
			if (wr_ok && apb_req.paddr == REG_CTRL)
				enable <= apb_req.pwdata[0];
			status <= status_nxt;
			// releases the parser once every flag is gone
			err_clear <= (status != '0) && (status_nxt == '0);
			if (cfg_valid)
				cmp_cfg <= cfg_data;
			if (word_done)
				word_count <= word_count + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/pkt_comm_pkg.sv
`default_nettype none

package pkt_comm_pkg;

	// ************************************************************
	// widths and protocol constants
	// ************************************************************
	localparam int ID_W = 16;
	localparam int LEN_W = 16;
	localparam int CFG_W = 32;
	localparam int APB_AW = 4;
	localparam int APB_DW = 32;

	localparam logic [7:0] PKT_VERSION = 8'd2;
	localparam logic [7:0] PKT_TYPE_WORD_LIST = 8'd1;
	localparam logic [7:0] PKT_TYPE_CMP_CONFIG = 8'd3;

	// version, type, id (2), length (2)
	localparam int HDR_LEN = 6;
	localparam int CMP_CFG_LEN = 4;

	// register map
	localparam logic [APB_AW-1:0] REG_CTRL = 4'h0;
	localparam logic [APB_AW-1:0] REG_STATUS = 4'h4;
	localparam logic [APB_AW-1:0] REG_CMP_CFG = 4'h8;
	localparam logic [APB_AW-1:0] REG_WORD_COUNT = 4'hC;

	// ************************************************************
	// structs
	// ************************************************************
	// sticky error flags, version in the top bit
	typedef struct packed {
		logic version;
		logic ptype;
		logic len;
		logic checksum;
		logic word;
	} err_bits_t;

	// one word buffer entry
	typedef struct packed {
		logic [7:0] chr;
		logic word_end;
		logic pkt_start;
		logic [ID_W-1:0] pkt_id;
	} word_char_t;

	typedef struct packed {
		logic [15:0] data;
		logic last;
	} out_beat_t;

	typedef struct packed {
		logic psel;
		logic penable;
		logic pwrite;
		logic [APB_AW-1:0] paddr;
		logic [APB_DW-1:0] pwdata;
	} apb_req_t;

	typedef struct packed {
		logic [APB_DW-1:0] prdata;
		logic pslverr;
	} apb_rsp_t;

endpackage

`default_nettype wire

//--- src/pkt_comm_top.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_comm_top import pkt_comm_pkg::*; #(
	parameter int PKT_MAX_LEN = 64,
	parameter int WORD_MAX_LEN = 8,
	parameter int BUF_DEPTH = 16
) (
	input wire logic CLK,
	input wire logic arst_n,
	input wire logic [7:0] in_data,
	input wire logic in_valid,
	output logic in_ready,
	output out_beat_t out_beat,
	output logic out_valid,
	input wire logic out_ready,
	input wire apb_req_t apb_req,
	output apb_rsp_t apb_rsp
);

	// parser to buffer
	word_char_t buf_entry;
	logic buf_push;
	logic buf_full;

	// buffer to emitter
	word_char_t buf_head;
	logic buf_empty;
	logic buf_pop;

	// register block side
	logic enable;
	logic err_clear;
	err_bits_t err_set;
	logic cfg_valid;
	logic [CFG_W-1:0] cfg_data;
	logic word_done;

	// ************************************************************
	// producer, buffer, consumer
	// ************************************************************
	pkt_header #(
		.PKT_MAX_LEN(PKT_MAX_LEN),
		.WORD_MAX_LEN(WORD_MAX_LEN)
	) u_header (
		.CLK(CLK), .arst_n(arst_n),
		.in_data(in_data), .in_valid(in_valid), .in_ready(in_ready),
		.enable(enable), .err_clear(err_clear),
		.buf_entry(buf_entry), .buf_push(buf_push), .buf_full(buf_full),
		.cfg_valid(cfg_valid), .cfg_data(cfg_data), .err_set(err_set)
	);

	word_buffer #(
		.BUF_DEPTH(BUF_DEPTH)
	) u_buffer (
		.CLK(CLK), .arst_n(arst_n),
		.push(buf_push), .din(buf_entry), .full(buf_full),
		.pop(buf_pop), .dout(buf_head), .empty(buf_empty)
	);

	word_emitter u_emitter (
		.CLK(CLK), .arst_n(arst_n),
		.head(buf_head), .empty(buf_empty), .pop(buf_pop),
		.out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
		.word_done(word_done)
	);

	// host register port
	apb_regs u_regs (
		.CLK(CLK), .arst_n(arst_n),
		.apb_req(apb_req), .apb_rsp(apb_rsp),
		.enable(enable), .err_set(err_set), .err_clear(err_clear),
		.cfg_valid(cfg_valid), .cfg_data(cfg_data), .word_done(word_done)
	);

endmodule

`default_nettype wire

//--- src/pkt_header.sv
`timescale 1ns/10ps
`default_nettype none

module pkt_header import pkt_comm_pkg::*; #(
	parameter int PKT_MAX_LEN = 64,
	parameter int WORD_MAX_LEN = 8
) (
	input wire logic CLK,
	input wire logic arst_n,
	input wire logic [7:0] in_data,
	input wire logic in_valid,
	output logic in_ready,
	input wire logic enable,
	input wire logic err_clear,
	output word_char_t buf_entry,
	output logic buf_push,
	input wire logic buf_full,
	output logic cfg_valid,
	output logic [CFG_W-1:0] cfg_data,
	output err_bits_t err_set
);

	localparam int HC_W = $clog2(HDR_LEN);
	localparam int WL_W = $clog2(WORD_MAX_LEN + 1);

	typedef enum logic [1:0] {S_HDR, S_PAYLOAD, S_CSUM, S_HALT} state_t;

	state_t state;
	logic [HC_W-1:0] hdr_cnt;
	logic [7:0] hdr_ver;
	logic [7:0] hdr_type;
	logic [7:0] len_lo;
	logic [ID_W-1:0] pkt_id;
	logic [LEN_W-1:0] pay_cnt;
	logic is_wlist;
	logic [7:0] csum;
	logic [WL_W-1:0] word_len;
	logic first_entry;
	logic [CFG_W-1:0] cfg_stage;

	logic take;
	logic hdr_last;
	logic pay_last;
	logic is_zero;
	logic word_err;
	logic [LEN_W-1:0] pkt_len;
	err_bits_t hdr_err;
	err_bits_t err_now;

	// ************************************************************
	// input handshake and error detection
	// ************************************************************
	// payload of a word list waits for room in the buffer
	always_comb begin
		case (state)
			S_HDR, S_CSUM: in_ready = enable;
			S_PAYLOAD: in_ready = enable && !(is_wlist && buf_full);
			default: in_ready = 1'b0;
		endcase
	end

	assign take = in_valid && in_ready;
	assign hdr_last = (hdr_cnt == HC_W'(HDR_LEN - 1));
	assign pay_last = (pay_cnt == LEN_W'(1));
	assign is_zero = (in_data == 8'h00);
	// length high byte is on the bus during the last header byte
	assign pkt_len = {in_data, len_lo};

	// overlong word, or payload not closed by a zero byte
	assign word_err = is_wlist && !is_zero
		&& (word_len == WL_W'(WORD_MAX_LEN) || pay_last);

	always_comb begin
		hdr_err = '0;
		hdr_err.version = (hdr_ver != PKT_VERSION);
		hdr_err.ptype = (hdr_type != PKT_TYPE_WORD_LIST) && (hdr_type != PKT_TYPE_CMP_CONFIG);
		hdr_err.len = (pkt_len == '0) || (pkt_len > LEN_W'(PKT_MAX_LEN))
			|| (hdr_type == PKT_TYPE_CMP_CONFIG && pkt_len != LEN_W'(CMP_CFG_LEN));
	end

	always_comb begin
		err_now = '0;
		if (take) begin
			case (state)
				S_HDR: if (hdr_last) err_now = hdr_err;
				S_PAYLOAD: err_now.word = word_err;
				S_CSUM: err_now.checksum = (in_data != csum);
				default: err_now = '0;
			endcase
		end
	end

	// ************************************************************
	// control FSM
	// ************************************************************
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			state <= S_HDR;
			hdr_cnt <= '0;
			pay_cnt <= '0;
			is_wlist <= 1'b0;
			word_len <= '0;
			first_entry <= 1'b0;
			buf_push <= 1'b0;
			cfg_valid <= 1'b0;
			err_set <= '0;
		end else begin
			buf_push <= 1'b0;
			cfg_valid <= 1'b0;
			err_set <= err_now;
			case (state)
				S_HDR: if (take) begin
					if (!hdr_last) begin
						hdr_cnt <= hdr_cnt + 1'b1;
					end else begin
						hdr_cnt <= '0;
						is_wlist <= (hdr_type == PKT_TYPE_WORD_LIST);
						pay_cnt <= pkt_len;
						word_len <= '0;
						first_entry <= 1'b1;
						state <= (|hdr_err) ? S_HALT : S_PAYLOAD;
					end
				end
				S_PAYLOAD: if (take) begin
					pay_cnt <= pay_cnt - 1'b1;
					if (is_wlist) begin
						buf_push <= 1'b1;
						first_entry <= 1'b0;
						word_len <= (is_zero || word_err) ? '0 : word_len + 1'b1;
					end
					if (word_err)
						state <= S_HALT;
					else if (pay_last)
						state <= S_CSUM;
				end
				S_CSUM: if (take) begin
					if (in_data != csum) begin
						state <= S_HALT;
					end else begin
						// staged config is applied only now
						cfg_valid <= !is_wlist;
						state <= S_HDR;
					end
				end
				default: if (err_clear) state <= S_HDR;
			endcase
		end
	end

	// ************************************************************
	// header fields, checksum, staging and buffer entry
	// ************************************************************
	always_ff @(posedge CLK) begin
		if (take && state == S_HDR) begin
			case (hdr_cnt)
				HC_W'(0): hdr_ver <= in_data;
				HC_W'(1): hdr_type <= in_data;
				HC_W'(2): pkt_id[7:0] <= in_data;
				HC_W'(3): pkt_id[15:8] <= in_data;
				HC_W'(4): len_lo <= in_data;
				default: csum <= '0;
			endcase
		end
		if (take && state == S_PAYLOAD) begin
			csum <= csum + in_data;
			// config bytes arrive low byte first
			if (!is_wlist)
				cfg_stage <= {in_data, cfg_stage[CFG_W-1:8]};
			// a bad byte closes the open word in its place
			buf_entry.chr <= (is_zero || word_err) ? 8'h00 : in_data;
			buf_entry.word_end <= is_zero || word_err;
			buf_entry.pkt_start <= first_entry;
			buf_entry.pkt_id <= pkt_id;
		end
	end

	assign cfg_data = cfg_stage;

endmodule

`default_nettype wire

//--- src/word_buffer.sv
`timescale 1ns/10ps
`default_nettype none

module word_buffer import pkt_comm_pkg::*; #(
	parameter int BUF_DEPTH = 16
) (
	input wire logic CLK,
	input wire logic arst_n,
	input wire logic push,
	input wire word_char_t din,
	output logic full,
	input wire logic pop,
	output word_char_t dout,
	output logic empty
);

	localparam int AW = $clog2(BUF_DEPTH);

	word_char_t mem [BUF_DEPTH];
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic [AW:0] count;

	// pointers carry a wrap bit above the address
	assign count = wr_ptr - rd_ptr;
	assign empty = (wr_ptr == rd_ptr);

	// full one entry early
	// the parser's push lands a cycle after it saw room
	assign full = (count >= (AW + 1)'(BUF_DEPTH - 1));

	// head entry straight from the array
	assign dout = mem[rd_ptr[AW-1:0]];

	always_ff @(posedge CLK) begin
		if (push && count != (AW + 1)'(BUF_DEPTH))
			mem[wr_ptr[AW-1:0]] <= din;
	end

	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push && count != (AW + 1)'(BUF_DEPTH))
				wr_ptr <= wr_ptr + 1'b1;
			if (pop && !empty)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- src/word_emitter.sv
`timescale 1ns/10ps
`default_nettype none

module word_emitter import pkt_comm_pkg::*; (
	input wire logic CLK,
	input wire logic arst_n,
	input wire word_char_t head,
	input wire logic empty,
	output logic pop,
	output out_beat_t out_beat,
	output logic out_valid,
	input wire logic out_ready,
	output logic word_done
);

	typedef enum logic [1:0] {P_ID, P_IDX, P_CHR} phase_t;

	phase_t phase;
	phase_t nxt_phase;
	logic [ID_W-1:0] word_idx;
	logic [7:0] pend_lo;
	logic [7:0] pend_hi;
	logic have_hi;

	logic slot_free;
	logic load;
	logic take_lo;
	logic take_hi;
	logic nxt_have_hi;
	out_beat_t nxt_beat;

	// output register may take a new beat
	assign slot_free = !out_valid || out_ready;

	// ************************************************************
	// beat sequencing
	// ************************************************************
	// pkt_id beat, index beat, then character pairs low byte first
	always_comb begin
		pop = 1'b0;
		load = 1'b0;
		take_lo = 1'b0;
		take_hi = 1'b0;
		nxt_phase = phase;
		nxt_have_hi = have_hi;
		nxt_beat = '0;
		case (phase)
			P_ID: if (!empty && slot_free) begin
				load = 1'b1;
				nxt_beat.data = head.pkt_id;
				nxt_phase = P_IDX;
			end
			P_IDX: if (slot_free) begin
				load = 1'b1;
				pop = 1'b1;
				nxt_beat.data = word_idx;
				if (head.word_end) begin
					// empty word ends on its index beat
					nxt_beat.last = 1'b1;
					nxt_phase = P_ID;
				end else begin
					take_lo = 1'b1;
					nxt_phase = P_CHR;
				end
			end
			default: if (!empty) begin
				if (!have_hi) begin
					if (!head.word_end) begin
						pop = 1'b1;
						take_hi = 1'b1;
						nxt_have_hi = 1'b1;
					end else if (slot_free) begin
						// lone last character, padded with zero
						pop = 1'b1;
						load = 1'b1;
						nxt_beat.data = {8'h00, pend_lo};
						nxt_beat.last = 1'b1;
						nxt_phase = P_ID;
					end
				end else if (slot_free) begin
					// full pair, head tells if it was the last one
					pop = 1'b1;
					load = 1'b1;
					nxt_have_hi = 1'b0;
					nxt_beat.data = {pend_hi, pend_lo};
					if (head.word_end) begin
						nxt_beat.last = 1'b1;
						nxt_phase = P_ID;
					end else begin
						take_lo = 1'b1;
					end
				end
			end
		endcase
	end

	// ************************************************************
	// state and output register
	// ************************************************************
	always_ff @(posedge CLK or negedge arst_n) begin
		if (!arst_n) begin
			phase <= P_ID;
			have_hi <= 1'b0;
			word_idx <= '0;
			out_valid <= 1'b0;
		end else begin
			phase <= nxt_phase;
			have_hi <= nxt_have_hi;
			// index restarts at the first word of a packet
			if (phase == P_ID && load && head.pkt_start)
				word_idx <= '0;
			else if (load && nxt_beat.last)
				word_idx <= word_idx + 1'b1;
			if (load)
				out_valid <= 1'b1;
			else if (out_ready)
				out_valid <= 1'b0;
		end
	end

	// beat payload and character holding registers
	always_ff @(posedge CLK) begin
		if (load)
			out_beat <= nxt_beat;
		if (take_lo)
			pend_lo <= head.chr;
		if (take_hi)
			pend_hi <= head.chr;
	end

	assign word_done = out_valid && out_ready && out_beat.last;

endmodule

`default_nettype wire
